// ==== hw/dataCacheSlot.sv ====
`timescale 1ns/1ps

module dataCacheSlot (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,

    input  logic              issueValid,
    input  lsuPkg::coreReqT   issueReq,
    output logic              slotFree,

    output logic              memValid,
    output memBusPkg::memReqT memReq,
    input  logic              memDone,
    input  memBusPkg::memRespT memResp,

    output logic              respValid,
    output lsuPkg::coreRespT  resp
);

    lsuPkg::slotStateT state;
    lsuPkg::coreReqT   held;

    logic accept;
    logic finish;

    assign slotFree = (state == lsuPkg::idle);
    assign accept   = rdy && slotFree && issueValid;
    assign finish   = rdy && (state == lsuPkg::waitMem) && memDone;

    // memory sees the held request for as long as the access runs
    assign memReq = held.op;

    // ##########################################################
    // slot FSM
    // ##########################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= lsuPkg::idle;
            memValid  <= 1'b0;
            respValid <= 1'b0;
        end else if (rdy) begin
            memValid  <= 1'b0;
            respValid <= 1'b0;
            case (state)
                lsuPkg::idle: begin
                    if (issueValid) begin
                        memValid <= 1'b1;
                        state    <= lsuPkg::waitMem;
                    end
                end
                lsuPkg::waitMem: begin
                    if (memDone) begin
                        respValid <= 1'b1;
                        state     <= lsuPkg::respond;
                    end
                end
                // response is on the outputs this cycle, free on the next
                lsuPkg::respond: state <= lsuPkg::idle;
                default: state <= lsuPkg::idle;
            endcase
        end
    end

    // held request and returned data
    always_ff @(posedge clk) begin
        if (accept) begin
            held <= issueReq;
        end
        if (finish) begin
            resp.tag  <= held.tag;
            resp.data <= held.op.isStore ? '0 : memResp.data;
        end
    end

endmodule

// ==== hw/loadStoreBuffer.sv ====
`timescale 1ns/1ps

`include "lsu_config.svh"

module loadStoreBuffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,

    input  logic              reqValid,
    input  memBusPkg::memReqT reqOp,
    output lsuPkg::tagT       nextTag,

    output logic              issueValid,
    output lsuPkg::coreReqT   issueReq,
    input  logic              slotFree
);

    localparam int depth = `LSU_QUEUE_DEPTH;
    localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntWidth = $clog2(depth + 1);

    typedef logic [ptrWidth-1:0] ptrT;
    typedef logic [cntWidth-1:0] cntT;

    lsuPkg::coreReqT entries [depth];

    ptrT         wrPtr;
    ptrT         rdPtr;
    cntT         count;
    lsuPkg::tagT tagCnt;

    logic push;
    logic pop;

    // wrap explicitly so a depth that is not a power of two still works
    function automatic ptrT advance(input ptrT p);
        if (p == ptrT'(depth - 1)) begin
            return '0;
        end
        return p + ptrT'(1);
    endfunction

    // ##########################################################
    // handshakes
    // ##########################################################

    // core strobes are never refused, the core bounds its outstanding count
    assign push = rdy && reqValid;
    assign pop  = rdy && issueValid && slotFree;

    assign issueValid = (count != '0);
    assign issueReq   = entries[rdPtr];
    assign nextTag    = tagCnt;

    // ##########################################################
    // pointers, count and tag counter
    // ##########################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr  <= '0;
            rdPtr  <= '0;
            count  <= '0;
            tagCnt <= '0;
        end else begin
            if (push) begin
                wrPtr  <= advance(wrPtr);
                tagCnt <= tagCnt + lsuPkg::tagT'(1);
            end
            if (pop) begin
                rdPtr <= advance(rdPtr);
            end
            case ({push, pop})
                2'b10: count <= count + cntT'(1);
                2'b01: count <= count - cntT'(1);
                default: count <= count;
            endcase
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr].op  <= reqOp;
            entries[wrPtr].tag <= tagCnt;
        end
    end

endmodule

// ==== hw/loadStoreUnit.sv ====
`timescale 1ns/1ps

module loadStoreUnit (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,

    input  logic              reqValid,
    input  memBusPkg::memReqT reqOp,
    output lsuPkg::tagT       nextTag,

    output logic              respValid,
    output lsuPkg::coreRespT  resp
);

    logic               issueValid;
    lsuPkg::coreReqT    issueReq;
    logic               slotFree;
    logic               memValid;
    memBusPkg::memReqT  memReq;
    logic               memDone;
    memBusPkg::memRespT memResp;

    // ##########################################################
    // queue, slot and memory in a chain
    // ##########################################################

    loadStoreBuffer buffer (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .reqValid   (reqValid),
        .reqOp      (reqOp),
        .nextTag    (nextTag),
        .issueValid (issueValid),
        .issueReq   (issueReq),
        .slotFree   (slotFree)
    );

    dataCacheSlot slot (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .issueValid (issueValid),
        .issueReq   (issueReq),
        .slotFree   (slotFree),
        .memValid   (memValid),
        .memReq     (memReq),
        .memDone    (memDone),
        .memResp    (memResp),
        .respValid  (respValid),
        .resp       (resp)
    );

    memoryController memory (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .memValid (memValid),
        .memReq   (memReq),
        .memDone  (memDone),
        .memResp  (memResp)
    );

endmodule

// ==== hw/lsuPkg.sv ====
`include "lsu_config.svh"

package lsuPkg;

    // ##########################################################
    // core-facing types
    // ##########################################################

    typedef logic [`LSU_TAG_WIDTH-1:0] tagT;

    // memory request stamped with its tag at the queue
    typedef struct packed {
        memBusPkg::memReqT op;
        tagT               tag;
    } coreReqT;

    // stores answer too, with zero data
    typedef struct packed {
        tagT             tag;
        memBusPkg::dataT data;
    } coreRespT;

    // ##########################################################
    // slot FSM
    // ##########################################################

    typedef enum logic [1:0] {
        idle,
        waitMem,
        respond
    } slotStateT;

endpackage

// ==== hw/lsu_config.svh ====
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// ##########################################################
// memory bus sizes
// ##########################################################

// byte address into the RAM
`define LSU_ADDR_WIDTH 12

// one data word, loads are zero-extended to this width
`define LSU_DATA_WIDTH 32

// ##########################################################
// queue and tag sizes
// ##########################################################

// tags roll over, one tag per queue entry keeps them unambiguous
`define LSU_TAG_WIDTH 3

`define LSU_QUEUE_DEPTH 8

// must equal 2**LSU_ADDR_WIDTH so that addresses wrap at the top
`define LSU_MEM_BYTES 4096

`endif

// ==== hw/memBusPkg.sv ====
`include "lsu_config.svh"

package memBusPkg;

    // ##########################################################
    // plain vectors
    // ##########################################################

    typedef logic [`LSU_ADDR_WIDTH-1:0] addrT;
    typedef logic [`LSU_DATA_WIDTH-1:0] dataT;

    // access size in bytes minus one: 0 byte, 1 halfword, 3 word
    typedef logic [1:0] lenT;

    // ##########################################################
    // transactions
    // ##########################################################

    typedef struct packed {
        logic isStore;
        addrT addr;
        lenT  len;
        dataT data;
    } memReqT;

    // response carries the gathered load word
    typedef struct packed {
        dataT data;
    } memRespT;

endpackage

// ==== hw/memoryController.sv ====
`timescale 1ns/1ps

`include "lsu_config.svh"

module memoryController (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,

    input  logic               memValid,
    input  memBusPkg::memReqT  memReq,
    output logic               memDone,
    output memBusPkg::memRespT memResp
);

    logic [7:0] ram [`LSU_MEM_BYTES];

    logic              busy;
    memBusPkg::lenT    byteCnt;
    memBusPkg::memReqT cur;
    memBusPkg::dataT   gathered;
    memBusPkg::addrT   byteAddr;

    logic start;
    logic step;
    logic lastByte;

    // ##########################################################
    // byte sequencing
    // ##########################################################

    assign start    = rdy && memValid && !busy;
    assign step     = rdy && busy;
    assign lastByte = (byteCnt == cur.len);

    // address arithmetic wraps at the top of memory
    assign byteAddr = cur.addr + memBusPkg::addrT'(byteCnt);

    assign memResp.data = gathered;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            byteCnt <= '0;
            memDone <= 1'b0;
        end else if (rdy) begin
            memDone <= 1'b0;
            if (start) begin
                busy    <= 1'b1;
                byteCnt <= '0;
            end else if (busy) begin
                if (lastByte) begin
                    busy    <= 1'b0;
                    memDone <= 1'b1;
                end else begin
                    byteCnt <= byteCnt + memBusPkg::lenT'(1);
                end
            end
        end
    end

    // ##########################################################
    // RAM and load word
    // ##########################################################

    // one byte per cycle, lowest address into the lowest byte lane
    always_ff @(posedge clk) begin
        if (start) begin
            cur      <= memReq;
            gathered <= '0;
        end else if (step) begin
            if (cur.isStore) begin
                ram[byteAddr] <= cur.data[{byteCnt, 3'b000} +: 8];
            end else begin
                gathered[{byteCnt, 3'b000} +: 8] <= ram[byteAddr];
            end
        end
    end

endmodule

// ==== loadStoreUnit.f ====
+incdir+hw
hw/memBusPkg.sv
hw/lsuPkg.sv
hw/loadStoreBuffer.sv
hw/dataCacheSlot.sv
hw/memoryController.sv
hw/loadStoreUnit.sv
verification/loadStoreUnitTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f loadStoreUnit.f --top-module loadStoreUnitTb -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -qx "Test OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== verification/loadStoreUnitTb.sv ====
`timescale 1ns/1ps

`include "lsu_config.svh"

module loadStoreUnitTb;

    // prefill, directed tests, burst and random loop
    localparam int totalReqs  = 32 + 2 + 6 + 6 + 8 + 300;
    localparam int cycleLimit = 20 * totalReqs + 200;
    localparam int maxOutstanding = `LSU_QUEUE_DEPTH;

    logic              clk;
    logic              rst;
    logic              rdy;
    logic              reqValid;
    memBusPkg::memReqT reqOp;
    lsuPkg::tagT       nextTag;
    logic              respValid;
    lsuPkg::coreRespT  resp;

    logic [7:0]       modelMem [`LSU_MEM_BYTES];
    lsuPkg::coreRespT expected [$];
    lsuPkg::coreRespT frontResp;
    lsuPkg::tagT      modelTag;

    int errors;
    int testErrors;
    int passCount;
    int failCount;
    int cycles;
    int stall;
    int gap;
    logic lastResp;
    logic lastRdy;

    logic            rIsStore;
    memBusPkg::addrT rAddr;
    memBusPkg::lenT  rLen;
    memBusPkg::dataT rData;

    loadStoreUnit dut (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .reqValid  (reqValid),
        .reqOp     (reqOp),
        .nextTag   (nextTag),
        .respValid (respValid),
        .resp      (resp)
    );

    always #10 clk = ~clk;

    // ##########################################################
    // model and helpers
    // ##########################################################

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got 0x%h, expected 0x%h", $time, name, got, exp);
            errors++;
        end
    endtask

    // little-endian with addresses wrapping at the top of memory
    function automatic memBusPkg::dataT modelLoad(input memBusPkg::addrT addr,
                                                  input memBusPkg::lenT len);
        memBusPkg::dataT word;
        word = '0;
        for (int i = 0; i <= int'(len); i++) begin
            word[8*i +: 8] = modelMem[memBusPkg::addrT'(addr + memBusPkg::addrT'(i))];
        end
        return word;
    endfunction

    function automatic void modelStore(input memBusPkg::addrT addr, input memBusPkg::lenT len,
                                       input memBusPkg::dataT data);
        for (int i = 0; i <= int'(len); i++) begin
            modelMem[memBusPkg::addrT'(addr + memBusPkg::addrT'(i))] = data[8*i +: 8];
        end
    endfunction

    task automatic sendReq(input logic isStore, input memBusPkg::addrT addr,
                           input memBusPkg::lenT len, input memBusPkg::dataT data);
        lsuPkg::coreRespT e;
        while (expected.size() >= maxOutstanding) begin
            @(posedge clk);
            #1;
        end
        checkValue("nextTag", 32'(nextTag), 32'(modelTag));
        e.tag = modelTag;
        if (isStore) begin
            modelStore(addr, len, data);
            e.data = '0;
        end else begin
            e.data = modelLoad(addr, len);
        end
        expected.push_back(e);
        modelTag = modelTag + lsuPkg::tagT'(1);
        reqValid      = 1'b1;
        reqOp.isStore = isStore;
        reqOp.addr    = addr;
        reqOp.len     = len;
        reqOp.data    = data;
        @(posedge clk);
        #1;
        reqValid = 1'b0;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic waitDrain();
        while (expected.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic endTest(input int num, input string name);
        if (errors == testErrors) begin
            passCount++;
            $display("test %0d %s: passed", num, name);
        end else begin
            failCount++;
            $display("test %0d %s: failed with %0d errors", num, name, errors - testErrors);
        end
        testErrors = errors;
    endtask

    // ##########################################################
    // response monitor and watchdog
    // ##########################################################

    always @(posedge clk) begin
        if (!rst) begin
            // a rise of respValid after a cycle with rdy low is a new response
            if (respValid && !lastResp && !lastRdy) begin
                $display("a new response appeared at time %0t while rdy was low", $time);
                errors++;
            end
            if (respValid && rdy) begin
                if (expected.size() == 0) begin
                    $display("a response with tag %0d arrived with no request outstanding",
                             resp.tag);
                    errors++;
                end else begin
                    frontResp = expected.pop_front();
                    checkValue("resp.tag", 32'(resp.tag), 32'(frontResp.tag));
                    checkValue("resp.data", resp.data, frontResp.data);
                end
            end
        end
        lastResp = respValid;
        lastRdy  = rdy;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Test FAILED");
            $finish;
        end
    end

    // ##########################################################
    // stimulus
    // ##########################################################

    initial begin
        void'($urandom(52385));
        clk = 1'b0;
        rst = 1'b1;
        rdy = 1'b1;
        reqValid = 1'b0;
        reqOp = '0;
        modelTag = '0;
        errors = 0;
        testErrors = 0;
        passCount = 0;
        failCount = 0;
        cycles = 0;
        lastResp = 1'b0;
        lastRdy = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        checkValue("respValid", 32'(respValid), 32'(0));
        checkValue("nextTag", 32'(nextTag), 32'(0));
        idleCycles(10);
        endTest(1, "reset state");

        sendReq(1'b1, 12'h080, 2'd3, 32'hCAFE1234);
        sendReq(1'b0, 12'h080, 2'd3, 32'h0);
        waitDrain();
        endTest(2, "word store and load");

        sendReq(1'b1, 12'h100, 2'd3, 32'h11223344);
        sendReq(1'b1, 12'h101, 2'd0, 32'h000000AA);
        sendReq(1'b1, 12'h102, 2'd1, 32'h0000BBCC);
        sendReq(1'b0, 12'h100, 2'd3, 32'h0);
        sendReq(1'b0, 12'h103, 2'd0, 32'h0);
        sendReq(1'b0, 12'h100, 2'd1, 32'h0);
        waitDrain();
        endTest(3, "sub-word merge");

        sendReq(1'b1, 12'h300, 2'd3, 32'h89ABCDEF);
        sendReq(1'b1, 12'h305, 2'd1, 32'h00005566);
        sendReq(1'b1, 12'h30A, 2'd0, 32'h00000077);
        sendReq(1'b0, 12'h300, 2'd3, 32'h0);
        sendReq(1'b0, 12'h305, 2'd1, 32'h0);
        sendReq(1'b0, 12'h30A, 2'd0, 32'h0);
        stall = 5 + int'($urandom % 16);
        rdy = 1'b0;
        idleCycles(stall);
        rdy = 1'b1;
        waitDrain();
        endTest(4, "stall with rdy low");

        for (int i = 0; i < 4; i++) begin
            sendReq(1'b1, memBusPkg::addrT'(12'h200 + 4 * i), 2'd3, 32'h0F0E0D00 + 32'(i));
        end
        sendReq(1'b0, 12'h200, 2'd3, 32'h0);
        sendReq(1'b0, 12'h205, 2'd0, 32'h0);
        sendReq(1'b0, 12'h20A, 2'd1, 32'h0);
        sendReq(1'b0, 12'h20C, 2'd3, 32'h0);
        waitDrain();
        endTest(5, "burst of eight");

        // fill 128 bytes around the wrap with a pattern from the whole address
        for (int i = 0; i < 32; i++) begin
            rAddr = memBusPkg::addrT'(12'hFC0 + 4 * i);
            sendReq(1'b1, rAddr, 2'd3, {rAddr, 8'h5A, rAddr});
        end
        for (int i = 0; i < 300; i++) begin
            rIsStore = logic'($urandom % 2);
            rAddr    = memBusPkg::addrT'(12'hFC0 + ($urandom % 125));
            rLen     = memBusPkg::lenT'($urandom % 3);
            if (rLen == 2'd2) begin
                rLen = 2'd3;
            end
            rData = $urandom;
            sendReq(rIsStore, rAddr, rLen, rData);
            gap = int'($urandom % 4);
            idleCycles(gap);
        end
        waitDrain();
        endTest(6, "random loads and stores");

        $display("tests passed: %0d, failed: %0d", passCount, failCount);
        if (errors == 0 && failCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
